//--- source/cache_pkg.sv
package cache_pkg;

	// Cache geometry
	localparam int WAYS     = 4;
	localparam int SETS     = 128;

	// Address split, tag | index | offset
	localparam int TAG_W    = 22;
	localparam int INDEX_W  = 7;
	localparam int OFFSET_W = 3;

	localparam int LANES    = 8;   // Byte lanes per line
	localparam int STATUS_W = 2;

	typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;
	typedef logic [TAG_W-1:0]                  tag_t;
	typedef logic [INDEX_W-1:0]                index_t;
	typedef logic [$clog2(WAYS)-1:0]           way_t;
	typedef logic [STATUS_W-1:0]               status_t;
	typedef logic [LANES*8-1:0]                line_t;
	typedef logic [11:0]                       flags_t;
	typedef logic [31:0]                       up_data_t;
	typedef logic [5:0]                        up_flags_t;
	typedef logic [1:0]                        order_t;

	// Status codes, values in between are aging steps
	localparam status_t ST_INVALID = 2'd0;
	localparam status_t ST_NEWEST  = 2'd3;

	// Upload sizes, code 3 is illegal
	localparam order_t ORD_BYTE = 2'd0;
	localparam order_t ORD_HALF = 2'd1;
	localparam order_t ORD_WORD = 2'd2;

endpackage

//--- source/cache_way_ram.sv
`timescale 1ns/1ps

module cache_way_ram #(
	parameter type payload_t = cache_pkg::line_t
) (
	input  logic              iCLOCK,
	input  logic              wr_en,
	input  cache_pkg::index_t wr_index,
	input  payload_t          wr_data,
	input  payload_t          wr_mask,
	input  cache_pkg::index_t rd_index,
	output payload_t          rd_data
);
	import cache_pkg::*;

	payload_t mem [SETS];

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			// Only masked bits change
			mem[wr_index] <= (mem[wr_index] & ~wr_mask) | (wr_data & wr_mask);
		end
		rd_data <= mem[rd_index];   // Registered read port
	end

endmodule

//--- source/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             iREMOVE,
	input  logic             iRD_REQ,
	input  cache_pkg::addr_t rd_addr,
	input  cache_pkg::addr_t up_addr,
	input  cache_pkg::addr_t wr_addr,
	input  logic             fill_en,
	input  logic             update_en,
	output logic             read_hit,
	output cache_pkg::way_t  read_way,
	output logic             up_hit,
	output cache_pkg::way_t  up_way,
	output cache_pkg::way_t  victim_way
);
	import cache_pkg::*;

	tag_t    tags   [WAYS][SETS];
	status_t status [WAYS][SETS];

	tag_t    rd_tag;
	tag_t    up_tag;
	tag_t    wr_tag;
	index_t  rd_index;
	index_t  up_index;
	index_t  wr_index;

	assign rd_tag   = rd_addr[OFFSET_W+INDEX_W +: TAG_W];
	assign up_tag   = up_addr[OFFSET_W+INDEX_W +: TAG_W];
	assign wr_tag   = wr_addr[OFFSET_W+INDEX_W +: TAG_W];
	assign rd_index = rd_addr[OFFSET_W +: INDEX_W];
	assign up_index = up_addr[OFFSET_W +: INDEX_W];
	assign wr_index = wr_addr[OFFSET_W +: INDEX_W];

	// Tag compare over all ways of one set
	function automatic logic lookup(input tag_t tag, input index_t index, output way_t way);
		logic hit;
		hit = 1'b0;
		way = '0;
		// Walk downwards so the lowest matching way is kept
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (status[w][index] != ST_INVALID && tags[w][index] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		return hit;
	endfunction

	always_comb begin
		read_hit = lookup(rd_tag, rd_index, read_way);
		up_hit   = lookup(up_tag, up_index, up_way);
	end

	// Victim is the lowest way at the lowest status, way 3 when all are newest
	always_comb begin
		victim_way = way_t'(WAYS - 1);
		for (int s = ST_NEWEST - 1; s >= 0; s--) begin
			for (int w = WAYS - 1; w >= 0; w--) begin
				if (status[w][wr_index] == status_t'(s)) begin
					victim_way = way_t'(w);
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (fill_en) begin
			tags[victim_way][wr_index] <= wr_tag;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					status[w][s] <= ST_INVALID;
				end
			end
		end else if (iREMOVE) begin
			// Invalidate every line
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					status[w][s] <= ST_INVALID;
				end
			end
		end else begin
			if (iRD_REQ && read_hit) begin
				status[read_way][rd_index] <= ST_NEWEST;   // Read-hit refresh
			end
			if (fill_en) begin
				for (int w = 0; w < WAYS; w++) begin
					if (way_t'(w) == victim_way) begin
						status[w][wr_index] <= ST_NEWEST;
					end else if (status[w][wr_index] >= status_t'(2)) begin
						// Aging step, ways at 1 stay put
						status[w][wr_index] <= status[w][wr_index] - 1'b1;
					end
				end
			end
			if (update_en && status[up_way][up_index] != ST_NEWEST) begin
				status[up_way][up_index] <= status[up_way][up_index] + 1'b1;   // Saturates at 3
			end
		end
	end

endmodule

//--- source/cache_write_steer.sv
`timescale 1ns/1ps

module cache_write_steer (
	input  logic                       iUP_REQ,
	input  cache_pkg::addr_t           up_addr,
	input  cache_pkg::order_t          up_order,
	input  cache_pkg::up_data_t        up_data,
	input  cache_pkg::up_flags_t       up_flags,
	input  logic                       up_hit,
	input  cache_pkg::way_t            up_way,
	input  logic                       iWR_REQ,
	input  cache_pkg::addr_t           wr_addr,
	input  cache_pkg::line_t           wr_data,
	input  cache_pkg::flags_t          wr_flags,
	input  cache_pkg::way_t            victim_way,
	output logic                       fill_en,
	output logic                       update_en,
	output cache_pkg::index_t          ram_wr_index,
	output cache_pkg::line_t           ram_wr_data,
	output cache_pkg::line_t           ram_wr_mask,
	output cache_pkg::flags_t          ram_wr_flags,
	output logic [cache_pkg::WAYS-1:0] ram_wr_en
);
	import cache_pkg::*;

	logic [OFFSET_W-1:0] offset;
	logic [LANES-1:0]    lane_mask;
	logic                order_ok;
	way_t                target_way;

	assign update_en  = iUP_REQ && up_hit;
	assign fill_en    = iWR_REQ && !iUP_REQ;   // Upload wins
	assign order_ok   = up_order <= ORD_WORD;
	assign offset     = up_addr[OFFSET_W-1:0];
	assign target_way = update_en ? up_way : victim_way;

	// Aligned lane select per upload size
	always_comb begin
		case (up_order)
			ORD_BYTE: lane_mask = LANES'(1) << offset;
			ORD_HALF: lane_mask = LANES'(3) << {offset[OFFSET_W-1:1], 1'b0};
			ORD_WORD: lane_mask = LANES'(15) << {offset[OFFSET_W-1], 2'b00};
			default:  lane_mask = '0;
		endcase
	end

	always_comb begin
		if (iUP_REQ) begin
			ram_wr_index = up_addr[OFFSET_W +: INDEX_W];
			ram_wr_data  = {up_data, up_data};     // Same word in both halves
			ram_wr_flags = {up_flags, up_flags};
			for (int l = 0; l < LANES; l++) begin
				ram_wr_mask[l*8 +: 8] = {8{lane_mask[l]}};
			end
		end else begin
			ram_wr_index = wr_addr[OFFSET_W +: INDEX_W];
			ram_wr_data  = wr_data;
			ram_wr_flags = wr_flags;
			ram_wr_mask  = '1;                     // Full line fill
		end
	end

	// Illegal order also keeps the flag RAM untouched
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			ram_wr_en[w] = ((update_en && order_ok) || fill_en) && target_way == way_t'(w);
		end
	end

endmodule

//--- source/cache_read_out.sv
`timescale 1ns/1ps

module cache_read_out (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  logic              iREMOVE,
	input  logic              iRD_REQ,
	input  logic              read_hit,
	input  cache_pkg::way_t   read_way,
	input  cache_pkg::line_t  way_data [cache_pkg::WAYS],
	input  cache_pkg::flags_t way_flags [cache_pkg::WAYS],
	output logic              oRD_VALID,
	output logic              oRD_HIT,
	output cache_pkg::line_t  oRD_DATA,
	output cache_pkg::flags_t oRD_MMU_FLAGS
);
	import cache_pkg::*;

	logic valid_q;
	logic hit_q;
	way_t way_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q   <= 1'b0;
			way_q   <= '0;
		end else begin
			valid_q <= iRD_REQ && !iREMOVE;   // Remove drops the read in flight
			hit_q   <= read_hit;
			way_q   <= read_way;
		end
	end

	assign oRD_VALID = valid_q;
	assign oRD_HIT   = valid_q && hit_q;

	// RAM outputs line up with the registered way
	assign oRD_DATA      = oRD_HIT ? way_data[way_q] : '0;
	assign oRD_MMU_FLAGS = oRD_HIT ? way_flags[way_q] : '0;

endmodule

//--- source/l1_cache.sv
`timescale 1ns/1ps

module l1_cache (
	input  logic                 iCLOCK,
	input  logic                 inRESET,
	input  logic                 iREMOVE,
	input  logic                 iRD_REQ,
	input  cache_pkg::addr_t     iRD_ADDR,
	output logic                 oRD_VALID,
	output logic                 oRD_HIT,
	output cache_pkg::line_t     oRD_DATA,
	output cache_pkg::flags_t    oRD_MMU_FLAGS,
	input  logic                 iUP_REQ,
	input  cache_pkg::order_t    iUP_ORDER,
	input  cache_pkg::addr_t     iUP_ADDR,
	input  cache_pkg::up_data_t  iUP_DATA,
	input  cache_pkg::up_flags_t iUP_MMU_FLAGS,
	input  logic                 iWR_REQ,
	input  cache_pkg::addr_t     iWR_ADDR,
	input  cache_pkg::line_t     iWR_DATA,
	input  cache_pkg::flags_t    iWR_MMU_FLAGS
);
	import cache_pkg::*;

	logic            read_hit;
	way_t            read_way;
	logic            up_hit;
	way_t            up_way;
	way_t            victim_way;
	logic            fill_en;
	logic            update_en;
	index_t          rd_index;
	index_t          ram_wr_index;
	line_t           ram_wr_data;
	line_t           ram_wr_mask;
	flags_t          ram_wr_flags;
	logic [WAYS-1:0] ram_wr_en;
	line_t           way_data  [WAYS];
	flags_t          way_flags [WAYS];

	assign rd_index = iRD_ADDR[OFFSET_W +: INDEX_W];

	cache_tag_array u_tag_array (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.iREMOVE    (iREMOVE),
		.iRD_REQ    (iRD_REQ),
		.rd_addr    (iRD_ADDR),
		.up_addr    (iUP_ADDR),
		.wr_addr    (iWR_ADDR),
		.fill_en    (fill_en),
		.update_en  (update_en),
		.read_hit   (read_hit),
		.read_way   (read_way),
		.up_hit     (up_hit),
		.up_way     (up_way),
		.victim_way (victim_way)
	);

	cache_write_steer u_write_steer (
		.iUP_REQ      (iUP_REQ),
		.up_addr      (iUP_ADDR),
		.up_order     (iUP_ORDER),
		.up_data      (iUP_DATA),
		.up_flags     (iUP_MMU_FLAGS),
		.up_hit       (up_hit),
		.up_way       (up_way),
		.iWR_REQ      (iWR_REQ),
		.wr_addr      (iWR_ADDR),
		.wr_data      (iWR_DATA),
		.wr_flags     (iWR_MMU_FLAGS),
		.victim_way   (victim_way),
		.fill_en      (fill_en),
		.update_en    (update_en),
		.ram_wr_index (ram_wr_index),
		.ram_wr_data  (ram_wr_data),
		.ram_wr_mask  (ram_wr_mask),
		.ram_wr_flags (ram_wr_flags),
		.ram_wr_en    (ram_wr_en)
	);

	// One data RAM and one flag RAM per way
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		cache_way_ram #(.payload_t(line_t)) u_data_ram (
			.iCLOCK   (iCLOCK),
			.wr_en    (ram_wr_en[w]),
			.wr_index (ram_wr_index),
			.wr_data  (ram_wr_data),
			.wr_mask  (ram_wr_mask),
			.rd_index (rd_index),
			.rd_data  (way_data[w])
		);

		cache_way_ram #(.payload_t(flags_t)) u_flag_ram (
			.iCLOCK   (iCLOCK),
			.wr_en    (ram_wr_en[w]),
			.wr_index (ram_wr_index),
			.wr_data  (ram_wr_flags),
			.wr_mask  ('1),   // Flags have no lanes
			.rd_index (rd_index),
			.rd_data  (way_flags[w])
		);
	end

	cache_read_out u_read_out (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.iREMOVE       (iREMOVE),
		.iRD_REQ       (iRD_REQ),
		.read_hit      (read_hit),
		.read_way      (read_way),
		.way_data      (way_data),
		.way_flags     (way_flags),
		.oRD_VALID     (oRD_VALID),
		.oRD_HIT       (oRD_HIT),
		.oRD_DATA      (oRD_DATA),
		.oRD_MMU_FLAGS (oRD_MMU_FLAGS)
	);

endmodule

//--- tb/l1_cache_chk.sv
`timescale 1ns/1ps

module l1_cache_chk (
	input logic              iCLOCK,
	input logic              inRESET,
	input logic              iREMOVE,
	input logic              iRD_REQ,
	input logic              oRD_VALID,
	input logic              oRD_HIT,
	input cache_pkg::line_t  oRD_DATA,
	input cache_pkg::flags_t oRD_MMU_FLAGS
);
	import cache_pkg::*;

	hit_needs_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		oRD_HIT |-> oRD_VALID)
		else $error("oRD_HIT is high while oRD_VALID is low");

	// Outputs are gated to zero on a miss
	zero_without_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!oRD_HIT |-> (oRD_DATA == line_t'(0) && oRD_MMU_FLAGS == flags_t'(0)))
		else $error("Read data or flags nonzero without a hit");

	valid_follows_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!$past(iREMOVE) |-> (oRD_VALID == $past(iRD_REQ)))
		else $error("oRD_VALID does not follow the read request of the previous cycle");

	remove_drops_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$past(iREMOVE) |-> !oRD_VALID)
		else $error("oRD_VALID is high in the cycle after a remove");

endmodule

//--- tb/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;
	import cache_pkg::*;

	localparam int CLK_HALF    = 10;
	localparam int DRIVE_DELAY = 1;
	localparam int WAIT_LIMIT  = 8;   // Cycles before a read counts as lost

	localparam logic [2:0] OP_WRITE  = 3'd1;
	localparam logic [2:0] OP_UPLOAD = 3'd2;
	localparam logic [2:0] OP_READ   = 3'd3;
	localparam logic [2:0] OP_RD_RM  = 3'd4;   // Read and remove at the same edge

	typedef struct packed {
		logic [2:0] op;
		addr_t      addr;
		line_t      data;        // Upload uses the low 32 bits
		flags_t     flags;       // Upload uses the low 6 bits
		order_t     order;
		logic       exp_hit;
		line_t      exp_data;
		flags_t     exp_flags;
	} entry_t;

	logic      iCLOCK;
	logic      inRESET;
	logic      iREMOVE;
	logic      iRD_REQ;
	addr_t     iRD_ADDR;
	logic      oRD_VALID;
	logic      oRD_HIT;
	line_t     oRD_DATA;
	flags_t    oRD_MMU_FLAGS;
	logic      iUP_REQ;
	order_t    iUP_ORDER;
	addr_t     iUP_ADDR;
	up_data_t  iUP_DATA;
	up_flags_t iUP_MMU_FLAGS;
	logic      iWR_REQ;
	addr_t     iWR_ADDR;
	line_t     iWR_DATA;
	flags_t    iWR_MMU_FLAGS;
	entry_t    op_table [$];

	l1_cache DUT (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.iREMOVE       (iREMOVE),
		.iRD_REQ       (iRD_REQ),
		.iRD_ADDR      (iRD_ADDR),
		.oRD_VALID     (oRD_VALID),
		.oRD_HIT       (oRD_HIT),
		.oRD_DATA      (oRD_DATA),
		.oRD_MMU_FLAGS (oRD_MMU_FLAGS),
		.iUP_REQ       (iUP_REQ),
		.iUP_ORDER     (iUP_ORDER),
		.iUP_ADDR      (iUP_ADDR),
		.iUP_DATA      (iUP_DATA),
		.iUP_MMU_FLAGS (iUP_MMU_FLAGS),
		.iWR_REQ       (iWR_REQ),
		.iWR_ADDR      (iWR_ADDR),
		.iWR_DATA      (iWR_DATA),
		.iWR_MMU_FLAGS (iWR_MMU_FLAGS)
	);

	bind l1_cache l1_cache_chk u_chk (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.iREMOVE       (iREMOVE),
		.iRD_REQ       (iRD_REQ),
		.oRD_VALID     (oRD_VALID),
		.oRD_HIT       (oRD_HIT),
		.oRD_DATA      (oRD_DATA),
		.oRD_MMU_FLAGS (oRD_MMU_FLAGS)
	);

	initial iCLOCK = 1'b0;
	always #CLK_HALF iCLOCK = ~iCLOCK;

	// Address layout is tag, index, offset
	function automatic addr_t make_addr(input int tag, input int index, input int offset);
		return {tag_t'(tag), index_t'(index), OFFSET_W'(offset)};
	endfunction

	task automatic add_entry(input logic [2:0] op, input addr_t addr, input line_t data,
			input flags_t flags, input order_t order, input logic exp_hit,
			input line_t exp_data, input flags_t exp_flags);
		entry_t e;
		e.op        = op;
		e.addr      = addr;
		e.data      = data;
		e.flags     = flags;
		e.order     = order;
		e.exp_hit   = exp_hit;
		e.exp_data  = exp_data;
		e.exp_flags = exp_flags;
		op_table.push_back(e);
	endtask

	task automatic apply_entry(input entry_t e);
		iRD_REQ       = (e.op == OP_READ) || (e.op == OP_RD_RM);
		iREMOVE       = (e.op == OP_RD_RM);
		iWR_REQ       = (e.op == OP_WRITE);
		iUP_REQ       = (e.op == OP_UPLOAD);
		iRD_ADDR      = e.addr;
		iWR_ADDR      = e.addr;
		iUP_ADDR      = e.addr;
		iWR_DATA      = e.data;
		iWR_MMU_FLAGS = e.flags;
		iUP_DATA      = e.data[31:0];
		iUP_MMU_FLAGS = e.flags[5:0];
		iUP_ORDER     = e.order;
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_read(input entry_t e, input int idx);
		int cycles;
		cycles = 0;
		@(negedge iCLOCK);
		while (!oRD_VALID && cycles < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			cycles++;
		end
		if (!oRD_VALID) begin
			$display("Read of table entry %0d got no valid response in %0d cycles",
				idx, WAIT_LIMIT);
			$display("Simulation failed");
			$fatal(1, "Read response timed out");
		end else begin
			check_value($sformatf("entry %0d read latency", idx), 64'(cycles), 64'd0);
			check_value($sformatf("entry %0d oRD_HIT", idx), 64'(oRD_HIT), 64'(e.exp_hit));
			check_value($sformatf("entry %0d oRD_DATA", idx), oRD_DATA, e.exp_data);
			check_value($sformatf("entry %0d oRD_MMU_FLAGS", idx), 64'(oRD_MMU_FLAGS),
				64'(e.exp_flags));
		end
	endtask

	// Remove at the sampling edge leaves no response
	task automatic check_no_valid(input int idx);
		@(negedge iCLOCK);
		check_value($sformatf("entry %0d oRD_VALID", idx), 64'(oRD_VALID), 64'd0);
		check_value($sformatf("entry %0d oRD_HIT", idx), 64'(oRD_HIT), 64'd0);
	endtask

	task automatic build_table();
		addr_t a_x;
		addr_t set5 [6];   // Tags A to F in set 5
		a_x = make_addr('h1234, 10, 0);
		for (int i = 0; i < 6; i++) begin
			set5[i] = make_addr('h100 + i, 5, 0);
		end
		// Empty cache after reset
		add_entry(OP_READ, make_addr('h3fffff, 127, 7), '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b0, '0, '0);
		// Fill and read back before a miss on another tag in the same set
		add_entry(OP_WRITE, a_x, 64'h0123_4567_89ab_cdef, 12'h5a3, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'h0123_4567_89ab_cdef, 12'h5a3);
		add_entry(OP_READ, make_addr('h1234, 10, 6), '0, '0, ORD_BYTE, 1'b1,
			64'h0123_4567_89ab_cdef, 12'h5a3);
		add_entry(OP_READ, make_addr('h1235, 10, 0), '0, '0, ORD_BYTE, 1'b0, '0, '0);
		// E takes the way of A after five fills into set 5
		for (int i = 0; i < 5; i++) begin
			add_entry(OP_WRITE, set5[i], {8{8'(8'h0a + i)}}, flags_t'(12'h10a + i), ORD_BYTE,
				1'b0, '0, '0);
		end
		add_entry(OP_READ, set5[0], '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, set5[4], '0, '0, ORD_BYTE, 1'b1, {8{8'h0e}}, 12'h10e);
		add_entry(OP_READ, set5[3], '0, '0, ORD_BYTE, 1'b1, {8{8'h0d}}, 12'h10d);
		// Refresh B so that F evicts C
		add_entry(OP_READ, set5[1], '0, '0, ORD_BYTE, 1'b1, {8{8'h0b}}, 12'h10b);
		add_entry(OP_WRITE, set5[5], {8{8'h0f}}, 12'h10f, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, set5[2], '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, set5[1], '0, '0, ORD_BYTE, 1'b1, {8{8'h0b}}, 12'h10b);
		add_entry(OP_READ, set5[3], '0, '0, ORD_BYTE, 1'b1, {8{8'h0d}}, 12'h10d);
		add_entry(OP_READ, set5[4], '0, '0, ORD_BYTE, 1'b1, {8{8'h0e}}, 12'h10e);
		add_entry(OP_READ, set5[5], '0, '0, ORD_BYTE, 1'b1, {8{8'h0f}}, 12'h10f);
		// Byte at offset 5 takes data byte 1
		add_entry(OP_UPLOAD, make_addr('h1234, 10, 5), 64'h4433_2211, 12'h02d, ORD_BYTE,
			1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'h0123_2267_89ab_cdef, 12'hb6d);
		// Halfword at offset 3 aligns down to lanes 2 and 3
		add_entry(OP_UPLOAD, make_addr('h1234, 10, 3), 64'h8877_6655, 12'h011, ORD_HALF,
			1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'h0123_2267_8877_cdef, 12'h451);
		add_entry(OP_UPLOAD, make_addr('h1234, 10, 6), 64'hfeed_beef, 12'h03f, ORD_WORD,
			1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'hfeed_beef_8877_cdef, 12'hfff);
		// Upload that misses leaves the cache alone
		add_entry(OP_UPLOAD, make_addr('h2222, 10, 4), 64'h1111_1111, 12'h001, ORD_WORD,
			1'b0, '0, '0);
		add_entry(OP_READ, make_addr('h2222, 10, 4), '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'hfeed_beef_8877_cdef, 12'hfff);
		add_entry(OP_UPLOAD, a_x, 64'h5555_5555, 12'h015, order_t'(3), 1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b1, 64'hfeed_beef_8877_cdef, 12'hfff);
		// Remove kills the read in flight and every line
		add_entry(OP_RD_RM, a_x, '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, a_x, '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, set5[1], '0, '0, ORD_BYTE, 1'b0, '0, '0);
		add_entry(OP_READ, set5[5], '0, '0, ORD_BYTE, 1'b0, '0, '0);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		inRESET = 1'b0;
		apply_entry('0);
		build_table();
		repeat (2) @(posedge iCLOCK);
		#DRIVE_DELAY;
		inRESET = 1'b1;
		foreach (op_table[i]) begin
			apply_entry(op_table[i]);
			@(posedge iCLOCK);   // DUT takes the operation here
			#DRIVE_DELAY;
			if (op_table[i].op == OP_READ || op_table[i].op == OP_RD_RM) begin
				apply_entry('0);
				if (op_table[i].op == OP_READ) begin
					check_read(op_table[i], i);
				end else begin
					check_no_valid(i);
				end
				@(posedge iCLOCK);
				#DRIVE_DELAY;
			end
		end
		apply_entry('0);
		@(posedge iCLOCK);
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- sim.f
source/cache_pkg.sv
source/cache_way_ram.sv
source/cache_tag_array.sv
source/cache_write_steer.sv
source/cache_read_out.sv
source/l1_cache.sv
tb/l1_cache_chk.sv
tb/tb_l1_cache.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_l1_cache \
		-f sim.f -Mdir obj_dir -o Vtb_l1_cache
	./obj_dir/Vtb_l1_cache

clean:
	rm -rf obj_dir
